/* Bender.yml */
package:
  name: soc_backbone

sources:
  - src/soc_pkg.sv
  - src/csr_bus_if.sv
  - src/reset_sequencer.sv
  - src/csr_bridge.sv
  - src/sysctl_gpio.sv
  - src/sysctl_timer.sv
  - src/soc_backbone.sv
  - target: test
    files:
      - testbench/tb_soc_backbone.sv

/* src.f */
src/soc_pkg.sv
src/csr_bus_if.sv
src/reset_sequencer.sv
src/csr_bridge.sv
src/sysctl_gpio.sv
src/sysctl_timer.sv
src/soc_backbone.sv
testbench/tb_soc_backbone.sv

/* src/csr_bridge.sv */
/*
 * Wishbone to CSR bridge
 * Turns each Wishbone slave cycle into one CSR access,
 * ack two cycles after strobe with the ORed slave read data
 */

`timescale 1ns/1ns

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
	input logic [soc_pkg::WB_DAT_W-1:0] wb_dat_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	csr_bus_if.bridge_mp csr
);

	logic [1:0] state;
	logic req;

	// New request only accepted when idle
	assign req = (state == soc_pkg::BRG_IDLE) && wb_cyc_i && wb_stb_i;

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= soc_pkg::BRG_IDLE;
			csr.csr_we <= 1'b0;
		end else begin
			// Write strobe lasts the access cycle only
			csr.csr_we <= 1'b0;
			case (state)
				soc_pkg::BRG_IDLE: begin
					if (req) begin
						state <= soc_pkg::BRG_ACCESS;
						csr.csr_we <= wb_we_i;
					end
				end
				// Slaves write or register read data here
				soc_pkg::BRG_ACCESS: state <= soc_pkg::BRG_ACK;
				default: state <= soc_pkg::BRG_IDLE;
			endcase
		end
	end

	// Word address and write data captured with the request
	always_ff @(posedge sys_clk) begin
		if (req) begin
			csr.csr_a.raw <= wb_adr_i[soc_pkg::CSR_ADR_W+1:2];
			csr.csr_dw <= wb_dat_i;
		end
	end

	// ----------------------------------------------------------------------
	// Wishbone response
	// ----------------------------------------------------------------------
	assign wb_ack_o = (state == soc_pkg::BRG_ACK);
	// Unaddressed slaves return zero, so OR is the read mux
	assign wb_dat_o = wb_ack_o ? (csr.dr_gpio | csr.dr_timer) : '0;

	a_ack_single: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		wb_ack_o |=> !wb_ack_o);

	a_we_in_access: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr.csr_we |-> (state == soc_pkg::BRG_ACCESS));

endmodule

/* src/csr_bus_if.sv */
/*
 * CSR bus
 * Request from the bridge, one registered read word per slave
 */

`timescale 1ns/1ns

interface csr_bus_if;

	// Request, driven by the bridge
	soc_pkg::csr_addr_u csr_a;
	logic csr_we;
	logic [soc_pkg::WB_DAT_W-1:0] csr_dw;

	// Read words, zero unless the slave is addressed
	logic [soc_pkg::WB_DAT_W-1:0] dr_gpio;
	logic [soc_pkg::WB_DAT_W-1:0] dr_timer;

	modport bridge_mp (output csr_a, output csr_we, output csr_dw,
		input dr_gpio, input dr_timer);

	modport gpio_mp (input csr_a, input csr_we, input csr_dw, output dr_gpio);

	modport timer_mp (input csr_a, input csr_we, input csr_dw, output dr_timer);

endinterface

/* src/reset_sequencer.sv */
/*
 * Reset sequencer
 * Releases the boot flash reset first, then the debounced system reset
 */

`timescale 1ns/1ns

module reset_sequencer (
	input logic sys_clk,
	input logic trigger_reset,
	output logic flash_rst_n_o,
	output logic sys_rst_o
);

	logic [soc_pkg::FLASH_CNT_W-1:0] flash_cnt;
	logic [soc_pkg::HOLD_CNT_W-1:0] hold_cnt;

	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			flash_cnt <= '0;
			hold_cnt <= soc_pkg::SYS_RST_CYCLES[soc_pkg::HOLD_CNT_W-1:0];
			sys_rst_o <= 1'b1;
		end else begin
			// Flash counter saturates at its terminal count
			if (flash_cnt != soc_pkg::FLASH_RST_CYCLES[soc_pkg::FLASH_CNT_W-1:0])
				flash_cnt <= flash_cnt + 1'b1;
			// Hold counter runs down to zero and stays there
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// One extra register stage on the system reset
			sys_rst_o <= (hold_cnt != '0);
		end
	end

	// Flash leaves reset once the count is reached
	assign flash_rst_n_o =
		(flash_cnt == soc_pkg::FLASH_RST_CYCLES[soc_pkg::FLASH_CNT_W-1:0]);

	// System must never run with the flash still held
	a_flash_before_sys: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		!sys_rst_o |-> flash_rst_n_o);

endmodule

/* src/soc_backbone.sv */
/*
 * SoC system-control backbone
 * Reset sequencer, Wishbone to CSR bridge, GPIO and timer slaves
 */

`timescale 1ns/1ns

module soc_backbone (
	input logic sys_clk,
	input logic trigger_reset,
	// Wishbone slave
	input logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i,
	input logic [soc_pkg::WB_DAT_W-1:0] wb_dat_i,
	output logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output logic wb_ack_o,
	// Buttons and LEDs
	input logic [soc_pkg::GPIO_IN_W-1:0] btn_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] led_o,
	// Interrupt lines
	output logic gpio_irq_o,
	output logic timer_irq_o,
	// Resets
	output logic flash_rst_n_o,
	output logic sys_rst_o
);

	csr_bus_if csr_bus ();

	// ----------------------------------------------------------------------
	// Reset generation, sys_rst_o drives every other block
	// ----------------------------------------------------------------------
	reset_sequencer u_reset_sequencer (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.flash_rst_n_o(flash_rst_n_o),
		.sys_rst_o(sys_rst_o)
	);

	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.csr(csr_bus.bridge_mp)
	);

	// System controller slaves, both in the same bank
	sysctl_gpio u_sysctl_gpio (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.csr(csr_bus.gpio_mp),
		.btn_i(btn_i),
		.led_o(led_o),
		.irq_o(gpio_irq_o)
	);

	sysctl_timer u_sysctl_timer (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst_o),
		.csr(csr_bus.timer_mp),
		.irq_o(timer_irq_o)
	);

endmodule

/* src/soc_pkg.sv */
/*
 * SoC backbone definitions
 * Register map of the system controller, CSR address layout,
 * reset sequencer counts and bridge state encodings
 */

package soc_pkg;

	// ----------------------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------------------
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	// CSR word address is Wishbone bits 15:2
	localparam int CSR_ADR_W = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 10;

	// ----------------------------------------------------------------------
	// System controller register map
	// ----------------------------------------------------------------------
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IRQ_EN = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CTRL = 10'd4;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_COMPARE = 10'd5;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_COUNTER = 10'd6;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd31;

	// Timer control bits
	localparam int TIMER_CTRL_EN = 0;
	localparam int TIMER_CTRL_AUTORELOAD = 1;

	// Buttons and LEDs
	localparam int GPIO_IN_W = 3;
	localparam int GPIO_OUT_W = 2;

	// Identity word, reads as "MONE"
	localparam logic [WB_DAT_W-1:0] SYSTEM_ID = 32'h4D4F4E45;

	// Reset counts, shortened for simulation
	localparam int FLASH_RST_CYCLES = 16;
	localparam int SYS_RST_CYCLES = 40;
	localparam int FLASH_CNT_W = $clog2(FLASH_RST_CYCLES + 1);
	localparam int HOLD_CNT_W = $clog2(SYS_RST_CYCLES + 1);

	// Bridge FSM states
	localparam logic [1:0] BRG_IDLE = 2'd0;
	localparam logic [1:0] BRG_ACCESS = 2'd1;
	localparam logic [1:0] BRG_ACK = 2'd2;

	// CSR address, raw word or bank/register split
	typedef struct packed {
		logic [CSR_BANK_W-1:0] bank;
		logic [CSR_REG_W-1:0] regnum;
	} csr_field_t;

	typedef union packed {
		logic [CSR_ADR_W-1:0] raw;
		csr_field_t fld;
	} csr_addr_u;

endpackage

/* src/sysctl_gpio.sv */
/*
 * System controller GPIO slave
 * Button inputs with change interrupt, LED outputs, system ID
 */

`timescale 1ns/1ns

module sysctl_gpio (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_bus_if.gpio_mp csr,
	input logic [soc_pkg::GPIO_IN_W-1:0] btn_i,
	output logic [soc_pkg::GPIO_OUT_W-1:0] led_o,
	output logic irq_o
);

	logic [soc_pkg::GPIO_IN_W-1:0] btn_meta;
	logic [soc_pkg::GPIO_IN_W-1:0] btn_sync;
	logic [soc_pkg::GPIO_IN_W-1:0] btn_prev;
	logic [soc_pkg::GPIO_IN_W-1:0] irq_en;
	logic bank_hit;

	assign bank_hit = (csr.csr_a.fld.bank == soc_pkg::SYSCTL_BANK);

	// Two-flop synchronizer, plus previous value for edge detect
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	// ----------------------------------------------------------------------
	// Control registers and interrupt
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			irq_en <= '0;
			irq_o <= 1'b0;
		end else begin
			// Any enabled input toggling
			irq_o <= |((btn_sync ^ btn_prev) & irq_en);
			if (csr.csr_we && bank_hit) begin
				case (csr.csr_a.fld.regnum)
					soc_pkg::REG_GPIO_OUT: led_o <= csr.csr_dw[soc_pkg::GPIO_OUT_W-1:0];
					soc_pkg::REG_GPIO_IRQ_EN: irq_en <= csr.csr_dw[soc_pkg::GPIO_IN_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Read word, registered every cycle
	always_ff @(posedge sys_clk) begin
		csr.dr_gpio <= '0;
		if (bank_hit) begin
			case (csr.csr_a.fld.regnum)
				soc_pkg::REG_GPIO_IN: csr.dr_gpio[soc_pkg::GPIO_IN_W-1:0] <= btn_sync;
				soc_pkg::REG_GPIO_OUT: csr.dr_gpio[soc_pkg::GPIO_OUT_W-1:0] <= led_o;
				soc_pkg::REG_GPIO_IRQ_EN: csr.dr_gpio[soc_pkg::GPIO_IN_W-1:0] <= irq_en;
				soc_pkg::REG_SYSTEM_ID: csr.dr_gpio <= soc_pkg::SYSTEM_ID;
				default: ;
			endcase
		end
	end

endmodule

/* src/sysctl_timer.sv */
/*
 * System controller compare timer
 * Counts up while enabled, interrupts and wraps on compare match,
 * one-shot unless autoreload is set
 */

`timescale 1ns/1ns

module sysctl_timer (
	input logic sys_clk,
	input logic sys_rst_i,
	csr_bus_if.timer_mp csr,
	output logic irq_o
);

	logic ctrl_en;
	logic ctrl_autoreload;
	logic [soc_pkg::WB_DAT_W-1:0] compare;
	logic [soc_pkg::WB_DAT_W-1:0] counter;
	logic [soc_pkg::WB_DAT_W-1:0] ctrl_word;
	logic bank_hit;
	logic hit;

	assign bank_hit = (csr.csr_a.fld.bank == soc_pkg::SYSCTL_BANK);
	assign hit = (counter == compare);

	// Control register as seen on the bus
	always_comb begin
		ctrl_word = '0;
		ctrl_word[soc_pkg::TIMER_CTRL_EN] = ctrl_en;
		ctrl_word[soc_pkg::TIMER_CTRL_AUTORELOAD] = ctrl_autoreload;
	end

	// ----------------------------------------------------------------------
	// Counter and registers
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ctrl_en <= 1'b0;
			ctrl_autoreload <= 1'b0;
			compare <= '0;
			counter <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= ctrl_en && hit;
			if (ctrl_en) begin
				if (hit) begin
					// Wrap, and stop here in one-shot mode
					counter <= '0;
					ctrl_en <= ctrl_autoreload;
				end else begin
					counter <= counter + 1'b1;
				end
			end
			// Bus writes take priority over counting
			if (csr.csr_we && bank_hit) begin
				case (csr.csr_a.fld.regnum)
					soc_pkg::REG_TIMER_CTRL: begin
						ctrl_en <= csr.csr_dw[soc_pkg::TIMER_CTRL_EN];
						ctrl_autoreload <= csr.csr_dw[soc_pkg::TIMER_CTRL_AUTORELOAD];
					end
					soc_pkg::REG_TIMER_COMPARE: compare <= csr.csr_dw;
					soc_pkg::REG_TIMER_COUNTER: counter <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// Read word, registered every cycle
	always_ff @(posedge sys_clk) begin
		csr.dr_timer <= '0;
		if (bank_hit) begin
			case (csr.csr_a.fld.regnum)
				soc_pkg::REG_TIMER_CTRL: csr.dr_timer <= ctrl_word;
				soc_pkg::REG_TIMER_COMPARE: csr.dr_timer <= compare;
				soc_pkg::REG_TIMER_COUNTER: csr.dr_timer <= counter;
				default: ;
			endcase
		end
	end

	// Pulse comes from a match seen while running
	a_irq_enabled: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		irq_o |-> $past(ctrl_en));

endmodule

/* testbench/tb_soc_backbone.sv */
/*
 * Testbench for the SoC system-control backbone
 * Wishbone master, shadow register model and read-back checks
 */

`timescale 1ns/1ns

module tb_soc_backbone;

	localparam int N_TRANS = 63;
	localparam int N_LOOP = 8;
	localparam int BTN_WAIT = 6;
	localparam int CMP_MAX = 12;
	localparam int ACK_LIMIT = 8;
	localparam int TIMEOUT_CYCLES = 20 * N_TRANS + 4 + soc_pkg::FLASH_RST_CYCLES
		+ soc_pkg::SYS_RST_CYCLES + N_LOOP * BTN_WAIT + 8 * (CMP_MAX + 4);

	logic sys_clk;
	logic trigger_reset;
	logic [soc_pkg::WB_ADR_W-1:0] wb_adr_i;
	logic [soc_pkg::WB_DAT_W-1:0] wb_dat_i;
	logic [soc_pkg::WB_DAT_W-1:0] wb_dat_o;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_ack_o;
	logic [soc_pkg::GPIO_IN_W-1:0] btn_i;
	logic [soc_pkg::GPIO_OUT_W-1:0] led_o;
	logic gpio_irq_o;
	logic timer_irq_o;
	logic flash_rst_n_o;
	logic sys_rst_o;

	// Shadow copy of the system controller registers
	logic [soc_pkg::GPIO_OUT_W-1:0] sh_led;
	logic [soc_pkg::GPIO_IN_W-1:0] sh_irq_en;
	logic [soc_pkg::GPIO_IN_W-1:0] sh_btn;
	logic sh_en;
	logic sh_autoreload;
	logic [31:0] sh_cmp;
	logic [31:0] sh_counter;

	// Read results waiting for the compare process
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;

	int cycle_cnt;
	int stb_cycle;
	int flash_at;
	int sys_at;
	int n;
	int pulses;
	int exp_pulses;
	int cmp;
	int stamps[4];
	logic [soc_pkg::GPIO_IN_W-1:0] new_btn;

	soc_backbone dut_i (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_ack_o(wb_ack_o),
		.btn_i(btn_i),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq_o),
		.timer_irq_o(timer_irq_o),
		.flash_rst_n_o(flash_rst_n_o),
		.sys_rst_o(sys_rst_o)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("Run exceeded its cycle limit");
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Inputs change 1 ns past the edge, outputs are sampled there too
	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	function automatic logic [31:0] csr_addr(input logic [3:0] bank, input logic [9:0] regnum);
		return {16'h0, bank, regnum, 2'b00};
	endfunction

	// ------------------------------------------------------------------
	// Reference model of the register map
	// ------------------------------------------------------------------
	function automatic logic [31:0] exp_read(input logic [31:0] addr);
		logic [31:0] word;
		word = '0;
		if (addr[15:12] == soc_pkg::SYSCTL_BANK) begin
			case (addr[11:2])
				soc_pkg::REG_GPIO_IN: word[soc_pkg::GPIO_IN_W-1:0] = sh_btn;
				soc_pkg::REG_GPIO_OUT: word[soc_pkg::GPIO_OUT_W-1:0] = sh_led;
				soc_pkg::REG_GPIO_IRQ_EN: word[soc_pkg::GPIO_IN_W-1:0] = sh_irq_en;
				soc_pkg::REG_SYSTEM_ID: word = 32'h4D4F4E45;
				soc_pkg::REG_TIMER_CTRL: begin
					word[soc_pkg::TIMER_CTRL_EN] = sh_en;
					word[soc_pkg::TIMER_CTRL_AUTORELOAD] = sh_autoreload;
				end
				soc_pkg::REG_TIMER_COMPARE: word = sh_cmp;
				soc_pkg::REG_TIMER_COUNTER: word = sh_counter;
				default: word = '0;
			endcase
		end
		return word;
	endfunction

	// Ack must come two cycles after stb is first sampled
	task automatic wait_ack();
		int waited;
		waited = 0;
		while (!wb_ack_o) begin
			next_cycle();
			waited++;
			if (waited > ACK_LIMIT)
				abort_run("No Wishbone ack within the cycle limit");
		end
		check("wb_ack_o latency", waited, 2);
	endtask

	task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
		wb_adr_i = addr;
		wb_dat_i = data;
		wb_we_i = 1'b1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		stb_cycle = cycle_cnt;
		wait_ack();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		// Shadow follows the write
		if (addr[15:12] == soc_pkg::SYSCTL_BANK) begin
			case (addr[11:2])
				soc_pkg::REG_GPIO_OUT: sh_led = data[soc_pkg::GPIO_OUT_W-1:0];
				soc_pkg::REG_GPIO_IRQ_EN: sh_irq_en = data[soc_pkg::GPIO_IN_W-1:0];
				soc_pkg::REG_TIMER_CTRL: begin
					sh_en = data[soc_pkg::TIMER_CTRL_EN];
					sh_autoreload = data[soc_pkg::TIMER_CTRL_AUTORELOAD];
				end
				soc_pkg::REG_TIMER_COMPARE: sh_cmp = data;
				soc_pkg::REG_TIMER_COUNTER: sh_counter = data;
				default: ;
			endcase
		end
		next_cycle();
		check("wb_ack_o", wb_ack_o, 1'b0);
	endtask

	task automatic wb_read(input logic [31:0] addr);
		wb_adr_i = addr;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		stb_cycle = cycle_cnt;
		wait_ack();
		exp_q.push_back(exp_read(addr));
		got_q.push_back(wb_dat_o);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		next_cycle();
		check("wb_ack_o", wb_ack_o, 1'b0);
	endtask

	// Compare process for read data
	always begin
		wait (got_q.size() != 0);
		cmp_got = got_q.pop_front();
		cmp_exp = exp_q.pop_front();
		check("wb_dat_o", cmp_got, cmp_exp);
	end

	initial begin
		void'($urandom(32'h32d2));
		trigger_reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i = '0;
		{sh_led, sh_irq_en, sh_btn, sh_en, sh_autoreload} = '0;
		sh_cmp = '0;
		sh_counter = '0;

		// ------------------------------------------------------------------
		// Reset release order, edge E counts as cycle 1
		// ------------------------------------------------------------------
		repeat (4) @(posedge sys_clk);
		#1 trigger_reset = 1'b0;
		n = 0;
		flash_at = 0;
		sys_at = 0;
		while (sys_at == 0) begin
			next_cycle();
			n++;
			if (flash_rst_n_o && flash_at == 0)
				flash_at = n;
			if (!sys_rst_o)
				sys_at = n;
			if (n > soc_pkg::SYS_RST_CYCLES + 8)
				abort_run("System reset was never released");
		end
		check("flash_rst_n_o release cycle", flash_at, soc_pkg::FLASH_RST_CYCLES);
		check("sys_rst_o release cycle", sys_at, soc_pkg::SYS_RST_CYCLES + 1);
		check("wb_ack_o", wb_ack_o, 1'b0);
		check("led_o", led_o, '0);
		check("gpio_irq_o", gpio_irq_o, 1'b0);
		check("timer_irq_o", timer_irq_o, 1'b0);

		// ID word, then holes in the map and foreign banks
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_SYSTEM_ID));
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, 10'd3));
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, 10'd100));
		wb_read(csr_addr(4'd2, soc_pkg::REG_SYSTEM_ID));
		wb_read(csr_addr(4'd0, soc_pkg::REG_GPIO_OUT));

		// LEDs and interrupt enables
		repeat (N_LOOP) begin
			wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT), $urandom);
			check("led_o", led_o, sh_led);
			wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IRQ_EN), $urandom);
			wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_OUT));
			wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IRQ_EN));
		end

		// ------------------------------------------------------------------
		// Buttons, change interrupt only on enabled bits
		// ------------------------------------------------------------------
		repeat (N_LOOP) begin
			wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IRQ_EN), $urandom);
			new_btn = $urandom;
			exp_pulses = (((new_btn ^ sh_btn) & sh_irq_en) != 0) ? 1 : 0;
			btn_i = new_btn;
			pulses = 0;
			repeat (BTN_WAIT) begin
				next_cycle();
				if (gpio_irq_o)
					pulses++;
			end
			sh_btn = new_btn;
			check("gpio_irq_o pulses", pulses, exp_pulses);
			wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IN));
		end

		// One-shot timer
		cmp = 3 + ($urandom % (CMP_MAX - 2));
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COMPARE), cmp);
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL), 32'h1);
		while (!timer_irq_o) begin
			if (cycle_cnt - stb_cycle >= cmp + 4)
				abort_run("No timer interrupt within compare plus 4 cycles");
			next_cycle();
		end
		pulses = 0;
		repeat (cmp + 4) begin
			next_cycle();
			if (timer_irq_o)
				pulses++;
		end
		check("timer_irq_o extra pulses", pulses, 0);
		// Match stops the timer and wraps the counter
		sh_en = 1'b0;
		sh_counter = '0;
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL));
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER));
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER), $urandom);
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER));

		// ------------------------------------------------------------------
		// Autoreload, pulse spacing compare plus 1
		// ------------------------------------------------------------------
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER), 32'h0);
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL), 32'h3);
		n = 0;
		while (n < 4) begin
			next_cycle();
			if (timer_irq_o) begin
				stamps[n] = cycle_cnt;
				n++;
			end
			if (cycle_cnt - stb_cycle > 4 * (cmp + 1) + 8)
				abort_run("Autoreload timer stopped raising interrupts");
		end
		for (int i = 1; i < 4; i++)
			check("timer_irq_o spacing", stamps[i] - stamps[i-1], cmp + 1);
		wb_write(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL), 32'h0);
		wb_read(csr_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL));

		wait (got_q.size() == 0);
		next_cycle();
		$display("Testbench passed");
		$finish;
	end

endmodule
